//--- common/nic_rx_consts.svh
`ifndef NIC_RX_CONSTS_SVH
`define NIC_RX_CONSTS_SVH

// ----------------------------------------
// Receive ring geometry
// ----------------------------------------

`define RX_BUF_AW       6                   // Address bits for 64 qwords
`define RX_BUF_DEPTH    (1 << `RX_BUF_AW)   // Entries in the ring

// ----------------------------------------
// DMA burst sizing
// ----------------------------------------

// Upper bound on qwords per TLP request
// Must fit into qword_count_t
`define MAX_TLP_QWORDS  16

`endif

//--- common/nic_rx_pkg.sv
package nic_rx_pkg;

    `include "nic_rx_consts.svh"

    // ----------------------------------------
    // Data path types
    // ----------------------------------------

    typedef logic [63:0]            qword_t;        // One MAC data word
    typedef logic [7:0]             byte_valid_t;   // Byte lane mask from the MAC

    // ----------------------------------------
    // Ring pointers
    // ----------------------------------------

    typedef logic [`RX_BUF_AW-1:0]  ring_addr_t;    // Plain memory address
    // Extra MSB is the wrap bit so full and empty differ
    typedef logic [`RX_BUF_AW:0]    ring_ptr_t;

    // ----------------------------------------
    // Counters
    // ----------------------------------------

    typedef logic [4:0]             qword_count_t;  // Burst length up to 16
    typedef logic [31:0]            frame_count_t;  // Event counter

    // ----------------------------------------
    // State machines
    // ----------------------------------------

    typedef enum logic [1:0] {
        rx_idle,                                    // Between frames
        rx_frame,                                   // Storing a frame
        rx_drop                                     // Ring overflowed, discard rest
    } rx_wr_state_t;

    typedef enum logic [1:0] {
        trig_idle,                                  // Looking for committed data
        trig_wait_ack,                              // Request held high
        trig_wait_rd                                // Waiting for DMA read pointer
    } tlp_trig_state_t;

endpackage

//--- rx_buffer/rx_frame_writer.sv
`include "nic_rx_consts.svh"

module rx_frame_writer
    import nic_rx_pkg::*;
(
    input  logic            xaui_clk_156_25_out,
    input  logic            reset_n,
    // MAC receive side
    input  qword_t          rx_data,
    input  byte_valid_t     rx_data_valid,
    input  logic            rx_good_frame,
    input  logic            rx_bad_frame,
    // Committed DMA read position
    input  ring_ptr_t       commited_rd_address,
    // Ring write port
    output ring_addr_t      wr_addr,
    output qword_t          wr_data,
    output logic            wr_en,
    // Frame boundary visible to the trigger
    output ring_ptr_t       commited_wr_address,
    // Statistics
    output frame_count_t    good_frame_count,
    output frame_count_t    bad_frame_count,
    output frame_count_t    drop_frame_count
);

    rx_wr_state_t   state;                          // Writer FSM
    ring_ptr_t      wr_ptr;                         // Speculative write pointer
    logic           data_in;                        // Qword present this cycle
    logic           ring_full;                      // No room for another qword
    logic           frame_end;                      // Either end pulse

    // ----------------------------------------
    // Write path
    // ----------------------------------------

    assign data_in   = |rx_data_valid;              // Any byte lane valid
    assign frame_end = rx_good_frame | rx_bad_frame;
    // Occupancy counted against what DMA has already released
    assign ring_full = (wr_ptr - commited_rd_address) == ring_ptr_t'(`RX_BUF_DEPTH);

    assign wr_en   = data_in & ~ring_full & (state != rx_drop); // Store unless dropping
    assign wr_addr = wr_ptr[`RX_BUF_AW-1:0];        // Drop the wrap bit
    assign wr_data = rx_data;                       // MAC word goes straight in

    // ----------------------------------------
    // Frame FSM and pointers
    // ----------------------------------------

    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            state               <= rx_idle;
            wr_ptr              <= '0;
            commited_wr_address <= '0;
        end else begin
            case (state)
                rx_idle, rx_frame: begin
                    if (rx_good_frame) begin
                        commited_wr_address <= wr_ptr;  // Publish whole frame
                        state               <= rx_idle;
                    end else if (rx_bad_frame) begin
                        wr_ptr <= commited_wr_address;  // Forget partial frame
                        state  <= rx_idle;
                    end else if (data_in) begin
                        if (ring_full) begin
                            state <= rx_drop;           // MAC cannot stall
                        end else begin
                            wr_ptr <= wr_ptr + ring_ptr_t'(1);
                            state  <= rx_frame;
                        end
                    end
                end
                rx_drop: begin
                    if (frame_end) begin
                        wr_ptr <= commited_wr_address;  // Discard what was stored
                        state  <= rx_idle;
                    end
                end
                default: state <= rx_idle;
            endcase
        end
    end

    // ----------------------------------------
    // Frame statistics
    // ----------------------------------------

    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            good_frame_count <= '0;
            bad_frame_count  <= '0;
            drop_frame_count <= '0;
        end else if (frame_end) begin
            if (state == rx_drop) begin
                drop_frame_count <= drop_frame_count + 32'd1;   // Overflowed frame
            end else if (rx_good_frame) begin
                good_frame_count <= good_frame_count + 32'd1;
            end else begin
                bad_frame_count  <= bad_frame_count + 32'd1;    // MAC flagged error
            end
        end
    end

endmodule

//--- rx_buffer/rx_ring_buffer.sv
`include "nic_rx_consts.svh"

module rx_ring_buffer
    import nic_rx_pkg::*;
(
    input  logic        xaui_clk_156_25_out,
    input  logic        reset_n,
    // Write port from the frame writer
    input  ring_addr_t  wr_addr,
    input  qword_t      wr_data,
    input  logic        wr_en,
    // DMA read port
    input  ring_addr_t  rd_addr,
    output qword_t      rd_data,
    // DMA read pointer update
    input  logic        rd_addr_change,
    input  ring_ptr_t   rd_addr_extended,
    output ring_ptr_t   commited_rd_address
);

    // ----------------------------------------
    // Qword storage
    // ----------------------------------------

    qword_t mem [0:`RX_BUF_DEPTH-1];               // Single clock, one write one read

    always_ff @(posedge xaui_clk_156_25_out) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;                // Written on the accepting edge
        end
    end

    // Registered read, data one cycle after address
    // A same-cycle read of the written entry returns the old word
    always_ff @(posedge xaui_clk_156_25_out) begin
        rd_data <= mem[rd_addr];
    end

    // ----------------------------------------
    // Committed read pointer
    // ----------------------------------------

    // Owned here since both writer and trigger need it
    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            commited_rd_address <= '0;
        end else if (rd_addr_change) begin
            commited_rd_address <= rd_addr_extended;    // DMA released up to here
        end
    end

endmodule

//--- verilog/tlp_trigger.sv
`include "nic_rx_consts.svh"

module tlp_trigger
    import nic_rx_pkg::*;
(
    input  logic            xaui_clk_156_25_out,
    input  logic            reset_n,
    // Committed pointers from both ends of the ring
    input  ring_ptr_t       commited_wr_address,
    input  ring_ptr_t       commited_rd_address,
    // DMA side handshake
    input  logic            trigger_tlp_ack,
    input  logic            rd_addr_change,
    output logic            trigger_tlp,
    output qword_count_t    qwords_to_send
);

    tlp_trig_state_t    state;                      // Trigger FSM
    ring_ptr_t          avail;                      // Committed but unread qwords
    qword_count_t       burst_len;                  // Capped request size

    // ----------------------------------------
    // Burst sizing
    // ----------------------------------------

    // Wrap bit makes the modular difference exact up to a full ring
    assign avail = commited_wr_address - commited_rd_address;

    always_comb begin
        if (avail > ring_ptr_t'(`MAX_TLP_QWORDS)) begin
            burst_len = qword_count_t'(`MAX_TLP_QWORDS);  // Cap at one TLP
        end else begin
            burst_len = qword_count_t'(avail);
        end
    end

    // ----------------------------------------
    // Request FSM
    // ----------------------------------------

    always_ff @(posedge xaui_clk_156_25_out or negedge reset_n) begin
        if (!reset_n) begin
            state          <= trig_idle;
            trigger_tlp    <= 1'b0;
            qwords_to_send <= '0;
        end else begin
            case (state)
                trig_idle: begin
                    if (avail != '0) begin
                        trigger_tlp    <= 1'b1;         // Raise request
                        qwords_to_send <= burst_len;    // Frozen until ack
                        state          <= trig_wait_ack;
                    end
                end
                trig_wait_ack: begin
                    if (trigger_tlp_ack) begin
                        trigger_tlp <= 1'b0;            // Drop on next edge
                        state       <= trig_wait_rd;
                    end
                end
                trig_wait_rd: begin
                    // Re-evaluate only after DMA has moved the read pointer
                    if (rd_addr_change) begin
                        state <= trig_idle;
                    end
                end
                default: begin
                    state       <= trig_idle;
                    trigger_tlp <= 1'b0;
                end
            endcase
        end
    end

endmodule

//--- verilog/nic_rx_top.sv
module nic_rx_top
    import nic_rx_pkg::*;
(
    input  logic            xaui_clk_156_25_out,
    input  logic            reset_n,
    // MAC receive side
    input  qword_t          rx_data,
    input  byte_valid_t     rx_data_valid,
    input  logic            rx_good_frame,
    input  logic            rx_bad_frame,
    // DMA read side
    input  ring_addr_t      rd_addr,
    output qword_t          rd_data,
    input  logic            rd_addr_change,
    input  ring_ptr_t       rd_addr_extended,
    // DMA request handshake
    input  logic            trigger_tlp_ack,
    output logic            trigger_tlp,
    output qword_count_t    qwords_to_send,
    // Statistics
    output frame_count_t    good_frame_count,
    output frame_count_t    bad_frame_count,
    output frame_count_t    drop_frame_count
);

    // ----------------------------------------
    // Internal wires
    // ----------------------------------------

    ring_addr_t     wr_addr;                        // Writer to ring
    qword_t         wr_data;
    logic           wr_en;
    ring_ptr_t      commited_wr_address;            // Writer to trigger
    ring_ptr_t      commited_rd_address;            // Ring to writer and trigger

    rx_frame_writer i_rx_frame_writer (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .rx_data             (rx_data),
        .rx_data_valid       (rx_data_valid),
        .rx_good_frame       (rx_good_frame),
        .rx_bad_frame        (rx_bad_frame),
        .commited_rd_address (commited_rd_address),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .wr_en               (wr_en),
        .commited_wr_address (commited_wr_address),
        .good_frame_count    (good_frame_count),
        .bad_frame_count     (bad_frame_count),
        .drop_frame_count    (drop_frame_count)
    );

    rx_ring_buffer i_rx_ring_buffer (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .wr_addr             (wr_addr),
        .wr_data             (wr_data),
        .wr_en               (wr_en),
        .rd_addr             (rd_addr),
        .rd_data             (rd_data),
        .rd_addr_change      (rd_addr_change),
        .rd_addr_extended    (rd_addr_extended),
        .commited_rd_address (commited_rd_address)
    );

    tlp_trigger i_tlp_trigger (
        .xaui_clk_156_25_out (xaui_clk_156_25_out),
        .reset_n             (reset_n),
        .commited_wr_address (commited_wr_address),
        .commited_rd_address (commited_rd_address),
        .trigger_tlp_ack     (trigger_tlp_ack),
        .rd_addr_change      (rd_addr_change),
        .trigger_tlp         (trigger_tlp),
        .qwords_to_send      (qwords_to_send)
    );

endmodule

//--- verification/nic_rx_assert.sv
`include "nic_rx_consts.svh"

module nic_rx_assert
    import nic_rx_pkg::*;
(
    input  logic            xaui_clk_156_25_out,
    input  logic            reset_n,
    input  logic            trigger_tlp,
    input  logic            trigger_tlp_ack,
    input  qword_count_t    qwords_to_send,
    input  ring_ptr_t       commited_wr_address,
    input  ring_ptr_t       commited_rd_address
);

    // ----------------------------------------
    // DMA request handshake
    // ----------------------------------------

    // Request level and size held until the ack pulse
    assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        trigger_tlp && !trigger_tlp_ack |=> trigger_tlp && $stable(qwords_to_send))
        else $error("trigger_tlp or qwords_to_send changed before the ack");

    assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        trigger_tlp |-> (qwords_to_send >= 5'd1) &&
                        (qwords_to_send <= qword_count_t'(`MAX_TLP_QWORDS)))
        else $error("qwords_to_send outside 1 to 16 during a request");

    // ----------------------------------------
    // Ring occupancy
    // ----------------------------------------

    assert property (@(posedge xaui_clk_156_25_out) disable iff (!reset_n)
        (commited_wr_address - commited_rd_address) <= ring_ptr_t'(`RX_BUF_DEPTH))
        else $error("Committed data exceeds the ring size");

endmodule

bind nic_rx_top nic_rx_assert i_nic_rx_assert (.*);

//--- verification/nic_rx_tb.sv
`include "nic_rx_consts.svh"

module nic_rx_tb;
    import nic_rx_pkg::*;

    logic           xaui_clk_156_25_out;
    logic           reset_n;
    qword_t         rx_data;
    byte_valid_t    rx_data_valid;
    logic           rx_good_frame;
    logic           rx_bad_frame;
    ring_addr_t     rd_addr;
    qword_t         rd_data;
    logic           rd_addr_change;
    ring_ptr_t      rd_addr_extended;
    logic           trigger_tlp_ack;
    logic           trigger_tlp;
    qword_count_t   qwords_to_send;
    frame_count_t   good_frame_count;
    frame_count_t   bad_frame_count;
    frame_count_t   drop_frame_count;

    // Reference model of the ring updated on each edge from driven inputs
    qword_t         m_mem [0:`RX_BUF_DEPTH-1];
    ring_ptr_t      m_wr = '0;                      // Speculative write pointer
    ring_ptr_t      m_commit = '0;                  // Committed write pointer
    ring_ptr_t      m_rd = '0;                      // Committed read pointer
    bit             m_drop = 0;
    qword_count_t   len_pre = '0;                   // Burst size the trigger would capture

    bit             dma_enable = 1;
    bit             dma_busy = 0;
    int             data_errors = 0;
    int             burst_errors = 0;
    int             count_errors = 0;
    int             other_errors = 0;
    int             cycle_limit = 0;
    bit             limit_ready = 0;

    byte            cmds [$];                       // Parsed tests file
    int             pa [$];
    int             pb [$];
    int             pc [$];

    nic_rx_top i_dut (.*);

    initial begin
        xaui_clk_156_25_out = 1'b0;
        forever #10 xaui_clk_156_25_out = ~xaui_clk_156_25_out;
    end

    // ----------------------------------------
    // Check tasks
    // ----------------------------------------

    task automatic check_qword(input qword_t got, input qword_t exp, input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
            data_errors++;
        end
    endtask

    task automatic check_burst_len(input qword_count_t got, input qword_count_t exp);
        if (got !== exp) begin
            $display("** Error at %0t: qwords_to_send got %0d expected %0d", $time, got, exp);
            burst_errors++;
        end
    endtask

    task automatic check_count(input frame_count_t got, input frame_count_t exp,
                               input string what);
        if (got !== exp) begin
            $display("** Error at %0t: %s got %0d expected %0d", $time, what, got, exp);
            count_errors++;
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------

    always @(posedge xaui_clk_156_25_out) begin : ring_model
        ring_ptr_t avail;
        avail = m_commit - m_rd;                    // Pre-edge view seen by the trigger
        len_pre = (avail > ring_ptr_t'(`MAX_TLP_QWORDS)) ?
                  qword_count_t'(`MAX_TLP_QWORDS) : qword_count_t'(avail);
        if (m_drop) begin
            if (rx_good_frame || rx_bad_frame) begin
                m_wr   = m_commit;                  // Overflowed frame discarded
                m_drop = 0;
            end
        end else if (rx_good_frame) begin
            m_commit = m_wr;
        end else if (rx_bad_frame) begin
            m_wr = m_commit;
        end else if (|rx_data_valid) begin
            if ((m_wr - m_rd) == ring_ptr_t'(`RX_BUF_DEPTH)) begin
                m_drop = 1;                         // No room so the rest of the frame is lost
            end else begin
                m_mem[m_wr[`RX_BUF_AW-1:0]] = rx_data;
                m_wr = m_wr + ring_ptr_t'(1);
            end
        end
        if (rd_addr_change) begin
            m_rd = rd_addr_extended;                // Write side above used the old value
        end
    end

    // ----------------------------------------
    // DMA engine
    // ----------------------------------------

    initial begin : dma_engine
        bit             latched;
        qword_count_t   exp_len;
        ring_ptr_t      base;
        int             delay;
        int             i;
        latched = 0;
        exp_len = '0;
        void'($urandom(25878));                     // Seed for the ack delays
        rd_addr          = '0;
        rd_addr_change   = 1'b0;
        rd_addr_extended = '0;
        trigger_tlp_ack  = 1'b0;
        forever begin
            @(posedge xaui_clk_156_25_out);
            #1;
            if (trigger_tlp && !latched) begin
                latched = 1;                        // Request rose on this edge
                exp_len = len_pre;
            end
            if (latched && dma_enable) begin
                dma_busy = 1;
                check_burst_len(qwords_to_send, exp_len);
                delay = $urandom % 4;
                repeat (delay) begin
                    @(posedge xaui_clk_156_25_out);
                    #1;
                end
                base = m_rd;
                for (i = 0; i < int'(exp_len); i++) begin
                    rd_addr = ring_addr_t'(base + ring_ptr_t'(i));
                    @(posedge xaui_clk_156_25_out);
                    #1;
                    check_qword(rd_data, m_mem[rd_addr], "rd_data");
                end
                trigger_tlp_ack = 1'b1;
                @(posedge xaui_clk_156_25_out);
                #1;
                trigger_tlp_ack  = 1'b0;
                rd_addr_change   = 1'b1;            // Release the burst
                rd_addr_extended = base + ring_ptr_t'(exp_len);
                @(posedge xaui_clk_156_25_out);
                #1;
                rd_addr_change = 1'b0;
                latched  = 0;
                dma_busy = 0;
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------

    function automatic qword_t make_qword(input int seed, input int idx);
        return {seed[15:0], idx[15:0], ~seed[15:0], 16'h5a00 ^ idx[15:0]};
    endfunction

    task automatic send_frame(input int len, input bit good, input int seed);
        int idx;
        for (idx = 0; idx < len; idx++) begin
            rx_data       = make_qword(seed, idx);
            rx_data_valid = (idx == len - 1) ? 8'h0f : 8'hff;   // Short last word
            @(posedge xaui_clk_156_25_out);
            #1;
        end
        rx_data       = '0;
        rx_data_valid = '0;
        rx_good_frame = good;
        rx_bad_frame  = !good;
        @(posedge xaui_clk_156_25_out);
        #1;
        rx_good_frame = 1'b0;
        rx_bad_frame  = 1'b0;
        @(posedge xaui_clk_156_25_out);
        #1;
    endtask

    task automatic wait_drained;
        repeat (3) begin
            @(posedge xaui_clk_156_25_out);
            #1;
        end
        while (!(m_rd == m_commit && !dma_busy && !trigger_tlp)) begin
            @(posedge xaui_clk_156_25_out);
            #1;
        end
    endtask

    task automatic read_tests(output bit ok, output int total_qwords);
        int     fd;
        int     r;
        int     a;
        int     b;
        int     c;
        byte    ch;
        string  line;
        ok = 0;
        total_qwords = 0;
        fd = $fopen("verification/nic_rx_tests.txt", "r");
        if (fd != 0) begin
            ok = 1;
            while (!$feof(fd)) begin
                r = $fgets(line, fd);
                if (r == 0 || line.len() < 1) continue;
                ch = line.getc(0);
                if (ch != "F" && ch != "D" && ch != "W" && ch != "E") continue;  // Comment lines
                a = 0;
                b = 0;
                c = 0;
                if (line.len() > 1) r = $sscanf(line.substr(1, line.len() - 1), "%d %d %d",
                                                a, b, c);
                cmds.push_back(ch);
                pa.push_back(a);
                pb.push_back(b);
                pc.push_back(c);
                if (ch == "F") total_qwords += a;
            end
            $fclose(fd);
        end
    endtask

    initial begin : watchdog
        int cycles;
        cycles = 0;
        wait (limit_ready);
        while (cycles < cycle_limit) begin
            @(posedge xaui_clk_156_25_out);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("Errors: data=%0d burst=%0d count=%0d other=%0d",
                 data_errors, burst_errors, count_errors, other_errors);
        $display("Test FAILED");
        $finish;
    end

    initial begin : main
        bit ok;
        int total;
        int k;
        reset_n          = 1'b0;
        rx_data          = '0;
        rx_data_valid    = '0;
        rx_good_frame    = 1'b0;
        rx_bad_frame     = 1'b0;
        read_tests(ok, total);
        cycle_limit = total * 8 + 200;
        limit_ready = 1;
        repeat (8) @(posedge xaui_clk_156_25_out);
        #1;
        reset_n = 1'b1;
        if (!ok) begin
            $display("Could not open verification/nic_rx_tests.txt");
            other_errors++;
        end else begin
            repeat (5) begin                        // No request without data
                @(posedge xaui_clk_156_25_out);
                #1;
                if (trigger_tlp !== 1'b0) begin
                    $display("** Error at %0t: trigger_tlp high before any frame", $time);
                    other_errors++;
                end
            end
            for (k = 0; k < cmds.size(); k++) begin
                case (cmds[k])
                    "F": send_frame(pa[k], pb[k] != 0, pc[k]);
                    "D": dma_enable = (pa[k] != 0);
                    "W": wait_drained();
                    "E": begin
                        check_count(good_frame_count, frame_count_t'(pa[k]), "good_frame_count");
                        check_count(bad_frame_count, frame_count_t'(pb[k]), "bad_frame_count");
                        check_count(drop_frame_count, frame_count_t'(pc[k]), "drop_frame_count");
                    end
                endcase
            end
        end
        $display("Errors: data=%0d burst=%0d count=%0d other=%0d",
                 data_errors, burst_errors, count_errors, other_errors);
        if (data_errors + burst_errors + count_errors + other_errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verification/nic_rx_tests.txt
# F len good(1)/bad(0) seed : send one frame
# D on(1)/off(0) : DMA engine enable, W : wait until ring drained
# E good bad drop : expected frame counters
F 1 1 1
F 8 1 2
F 40 1 3
W
F 40 1 4
W
F 5 1 5
F 7 0 6
F 6 1 7
W
F 3 0 8
F 20 1 9
F 33 1 10
W
D 0
F 30 1 11
F 30 1 12
F 10 1 13
F 4 1 14
F 2 0 15
D 1
W
F 12 1 16
W
E 12 2 2

//--- build.f
+incdir+common
common/nic_rx_pkg.sv
rx_buffer/rx_frame_writer.sv
rx_buffer/rx_ring_buffer.sv
verilog/tlp_trigger.sv
verilog/nic_rx_top.sv
verification/nic_rx_assert.sv
verification/nic_rx_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the receive path testbench with Verilator, from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module nic_rx_tb \
    -Mdir obj_dir -o nic_rx_sim || { echo "Build failed"; exit 1; }

./obj_dir/nic_rx_sim > sim.log 2>&1 ; cat sim.log

grep -q "^Test OK$" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }
